// ==== Makefile ====
# Verilator build and run of the TAP controller testbench

VERILATOR ?= verilator
TOP       ?= tb_tapc
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SRCS := $(shell grep -v '^+' sim.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): sim.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f sim.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim.f ====
source/tap_fsm_pkg.sv
source/tap_dr_pkg.sv
source/tap_ctrl_if.sv
source/tap_fsm.sv
source/tap_ir.sv
source/tap_dr_chains.sv
source/tap_tdo_out.sv
source/tapc_top.sv
tb/tapc_checker.sv
tb/tb_tapc.sv

// ==== source/tap_ctrl_if.sv ====
// ------------------------------------------------
// TAP state, internal reset and scan strobes
// shared by the controller submodules
// ------------------------------------------------
`default_nettype none

interface tap_ctrl_if;

    tap_fsm_pkg::tap_state_e state;  // Current TAP state
    logic sync_rst_n;                // Low while in Test-Logic-Reset
    logic ir_shift;                  // State is Shift-IR
    logic dr_capture;                // State is Capture-DR
    logic dr_shift;                  // State is Shift-DR
    logic dr_update;                 // State is Update-DR

    // Producer side
    modport fsm (
        output state, sync_rst_n, ir_shift, dr_capture, dr_shift, dr_update
    );

    // Consumer side
    modport ctrl (
        input state, sync_rst_n, ir_shift, dr_capture, dr_shift, dr_update
    );

endinterface

`default_nettype wire

// ==== source/tap_dr_chains.sv ====
// ------------------------------------------------
// Instruction decode, BYPASS and IDCODE data
// registers, DMI chain select and DR output mux
// ------------------------------------------------
`default_nettype none

module tap_dr_chains (
    input  logic tck,
    input  logic trst_n,
    input  logic tdi,
    tap_ctrl_if.ctrl ctrl,
    input  tap_fsm_pkg::tap_instr_e instr,
    input  logic [tap_dr_pkg::tap_idcode_width-1:0] fuse_idcode,
    input  logic dmi_ch_tdo,
    output logic dmi_ch_sel,
    output tap_dr_pkg::dmi_ch_id_t dmi_ch_id,
    output logic dr_tdo
);

    logic bypass_sel;
    logic idcode_sel;
    logic [tap_dr_pkg::tap_bypass_width-1:0] bypass_reg;
    logic [tap_dr_pkg::tap_idcode_width-1:0] idcode_reg;

    // ------------------------------------------------
    // Instruction decode and serial output mux
    // ------------------------------------------------
    always_comb begin
        bypass_sel = 1'b0;
        idcode_sel = 1'b0;
        dmi_ch_sel = 1'b0;
        dmi_ch_id  = '0;
        dr_tdo     = 1'b0;
        case (instr)
            tap_fsm_pkg::tap_instr_idcode: begin
                idcode_sel = 1'b1;
                dr_tdo     = idcode_reg[0];
            end
            tap_fsm_pkg::tap_instr_dtmcs: begin
                dmi_ch_sel = 1'b1;
                dmi_ch_id  = tap_dr_pkg::dmi_ch_id_dtmcs;
                dr_tdo     = dmi_ch_tdo;  // External chain
            end
            tap_fsm_pkg::tap_instr_dmi_access: begin
                dmi_ch_sel = 1'b1;
                dmi_ch_id  = tap_dr_pkg::dmi_ch_id_access;
                dr_tdo     = dmi_ch_tdo;
            end
            default: begin  // BYPASS and every unknown code
                bypass_sel = 1'b1;
                dr_tdo     = bypass_reg[0];
            end
        endcase
    end

    // BYPASS register, captures 0
    always_ff @(posedge tck) begin
        if (bypass_sel && ctrl.dr_capture) begin
            bypass_reg <= '0;
        end else if (bypass_sel && ctrl.dr_shift) begin
            bypass_reg <= tap_dr_pkg::tap_bypass_width'({tdi, bypass_reg} >> 1);
        end
    end

    // IDCODE register, captures the fuse value
    always_ff @(posedge tck) begin
        if (idcode_sel && ctrl.dr_capture) begin
            idcode_reg <= fuse_idcode;
        end else if (idcode_sel && ctrl.dr_shift) begin
            idcode_reg <= {tdi, idcode_reg[tap_dr_pkg::tap_idcode_width-1:1]};
        end
    end

    // Sampled into the TDO stage on the falling edge
    dmi_tdo_known_a: assert property (
        @(negedge tck) disable iff (!trst_n)
        (dmi_ch_sel && ctrl.dr_shift) |-> !$isunknown(dmi_ch_tdo)
    ) else $error("tap_dr_chains: dmi_ch_tdo unknown in Shift-DR");

endmodule

`default_nettype wire

// ==== source/tap_dr_pkg.sv ====
// ------------------------------------------------
// Data register widths and DMI scan chain ids
// ------------------------------------------------
`default_nettype none

package tap_dr_pkg;

    // Data register lengths
    localparam int unsigned tap_idcode_width = 32;
    localparam int unsigned tap_bypass_width = 1;

    // Chain id presented to the debug module interface
    typedef logic [1:0] dmi_ch_id_t;

    localparam dmi_ch_id_t dmi_ch_id_dtmcs  = 2'd1;  // DTM control/status
    localparam dmi_ch_id_t dmi_ch_id_access = 2'd2;  // DMI access register

endpackage

`default_nettype wire

// ==== source/tap_fsm.sv ====
// ------------------------------------------------
// TAP state machine with internal sync reset and
// registered capture, shift and update strobes
// ------------------------------------------------
`default_nettype none

module tap_fsm (
    input  logic tck,
    input  logic trst_n,
    input  logic tms,
    tap_ctrl_if.fsm ctrl
);

    tap_fsm_pkg::tap_state_e state_next;

    // ------------------------------------------------
    // State register and next state
    // ------------------------------------------------
    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) ctrl.state <= tap_fsm_pkg::tap_st_reset;
        else         ctrl.state <= state_next;
    end

    always_comb begin
        case (ctrl.state)
            tap_fsm_pkg::tap_st_reset:
                state_next = tms ? tap_fsm_pkg::tap_st_reset : tap_fsm_pkg::tap_st_idle;
            tap_fsm_pkg::tap_st_idle:
                state_next = tms ? tap_fsm_pkg::tap_st_dr_sel_scan : tap_fsm_pkg::tap_st_idle;
            tap_fsm_pkg::tap_st_dr_sel_scan:
                state_next = tms ? tap_fsm_pkg::tap_st_ir_sel_scan
                                 : tap_fsm_pkg::tap_st_dr_capture;
            tap_fsm_pkg::tap_st_dr_capture,
            tap_fsm_pkg::tap_st_dr_shift:
                state_next = tms ? tap_fsm_pkg::tap_st_dr_exit1 : tap_fsm_pkg::tap_st_dr_shift;
            tap_fsm_pkg::tap_st_dr_exit1:
                state_next = tms ? tap_fsm_pkg::tap_st_dr_update : tap_fsm_pkg::tap_st_dr_pause;
            tap_fsm_pkg::tap_st_dr_pause:
                state_next = tms ? tap_fsm_pkg::tap_st_dr_exit2 : tap_fsm_pkg::tap_st_dr_pause;
            tap_fsm_pkg::tap_st_dr_exit2:
                state_next = tms ? tap_fsm_pkg::tap_st_dr_update : tap_fsm_pkg::tap_st_dr_shift;
            tap_fsm_pkg::tap_st_ir_sel_scan:  // TMS high here wraps back to reset
                state_next = tms ? tap_fsm_pkg::tap_st_reset : tap_fsm_pkg::tap_st_ir_capture;
            tap_fsm_pkg::tap_st_ir_capture,
            tap_fsm_pkg::tap_st_ir_shift:
                state_next = tms ? tap_fsm_pkg::tap_st_ir_exit1 : tap_fsm_pkg::tap_st_ir_shift;
            tap_fsm_pkg::tap_st_ir_exit1:
                state_next = tms ? tap_fsm_pkg::tap_st_ir_update : tap_fsm_pkg::tap_st_ir_pause;
            tap_fsm_pkg::tap_st_ir_pause:
                state_next = tms ? tap_fsm_pkg::tap_st_ir_exit2 : tap_fsm_pkg::tap_st_ir_pause;
            tap_fsm_pkg::tap_st_ir_exit2:
                state_next = tms ? tap_fsm_pkg::tap_st_ir_update : tap_fsm_pkg::tap_st_ir_shift;
            default:  // Both update states
                state_next = tms ? tap_fsm_pkg::tap_st_dr_sel_scan : tap_fsm_pkg::tap_st_idle;
        endcase
    end

    // Internal reset, changes on falling edge
    always_ff @(negedge tck or negedge trst_n) begin
        if (!trst_n) ctrl.sync_rst_n <= 1'b0;
        else         ctrl.sync_rst_n <= (ctrl.state != tap_fsm_pkg::tap_st_reset);
    end

    // ------------------------------------------------
    // Strobes, high for the whole matching state
    // ------------------------------------------------
    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            ctrl.ir_shift   <= 1'b0;
            ctrl.dr_capture <= 1'b0;
            ctrl.dr_shift   <= 1'b0;
            ctrl.dr_update  <= 1'b0;
        end else begin
            // Decoded from the state being entered
            ctrl.ir_shift   <= ctrl.sync_rst_n && (state_next == tap_fsm_pkg::tap_st_ir_shift);
            ctrl.dr_capture <= ctrl.sync_rst_n && (state_next == tap_fsm_pkg::tap_st_dr_capture);
            ctrl.dr_shift   <= ctrl.sync_rst_n && (state_next == tap_fsm_pkg::tap_st_dr_shift);
            ctrl.dr_update  <= ctrl.sync_rst_n && (state_next == tap_fsm_pkg::tap_st_dr_update);
        end
    end

    // TMS must be driven whenever the TAP is out of reset
    tms_known_a: assert property (@(posedge tck) disable iff (!trst_n) !$isunknown(tms))
        else $error("tap_fsm: tms unknown");

endmodule

`default_nettype wire

// ==== source/tap_fsm_pkg.sv ====
// ------------------------------------------------
// TAP controller state encoding, instruction
// register width, opcodes and IR capture pattern
// ------------------------------------------------
`default_nettype none

package tap_fsm_pkg;

    // Sixteen states of the IEEE 1149.1 TAP controller
    typedef enum logic [3:0] {
        tap_st_reset       = 4'h0,  // Test-Logic-Reset
        tap_st_idle        = 4'h1,  // Run-Test/Idle
        tap_st_dr_sel_scan = 4'h2,
        tap_st_dr_capture  = 4'h3,
        tap_st_dr_shift    = 4'h4,
        tap_st_dr_exit1    = 4'h5,
        tap_st_dr_pause    = 4'h6,
        tap_st_dr_exit2    = 4'h7,
        tap_st_dr_update   = 4'h8,
        tap_st_ir_sel_scan = 4'h9,
        tap_st_ir_capture  = 4'hA,
        tap_st_ir_shift    = 4'hB,
        tap_st_ir_exit1    = 4'hC,
        tap_st_ir_pause    = 4'hD,
        tap_st_ir_exit2    = 4'hE,
        tap_st_ir_update   = 4'hF
    } tap_state_e;

    localparam int unsigned tap_ir_width = 5;

    // Supported opcodes, any other code acts as BYPASS
    typedef enum logic [tap_ir_width-1:0] {
        tap_instr_idcode     = 5'h01,
        tap_instr_dtmcs      = 5'h10,
        tap_instr_dmi_access = 5'h11,
        tap_instr_bypass     = 5'h1F
    } tap_instr_e;

    // Loaded in Capture-IR, LSB must be 1 per 1149.1
    localparam logic [tap_ir_width-1:0] tap_ir_capture_value = 5'b00001;

endpackage

`default_nettype wire

// ==== source/tap_ir.sv ====
// ------------------------------------------------
// Instruction shift register and the current
// instruction, updated on the falling edge
// ------------------------------------------------
`default_nettype none

module tap_ir (
    input  logic tck,
    input  logic trst_n,
    input  logic tdi,
    tap_ctrl_if.ctrl ctrl,
    output tap_fsm_pkg::tap_instr_e instr,
    output logic ir_tdo
);

    logic [tap_fsm_pkg::tap_ir_width-1:0] ir_sreg;  // Shift stage

    // ------------------------------------------------
    // Shift stage, LSB leaves first
    // ------------------------------------------------
    always_ff @(posedge tck) begin
        if (ctrl.state == tap_fsm_pkg::tap_st_ir_capture) begin
            ir_sreg <= tap_fsm_pkg::tap_ir_capture_value;
        end else if (ctrl.ir_shift) begin
            ir_sreg <= {tdi, ir_sreg[tap_fsm_pkg::tap_ir_width-1:1]};  // TDI in at MSB
        end
    end

    assign ir_tdo = ir_sreg[0];

    // ------------------------------------------------
    // Current instruction
    // ------------------------------------------------
    always_ff @(negedge tck or negedge trst_n) begin
        if (!trst_n) begin
            instr <= tap_fsm_pkg::tap_instr_idcode;
        end else if (!ctrl.sync_rst_n) begin
            instr <= tap_fsm_pkg::tap_instr_idcode;  // Held while in Test-Logic-Reset
        end else if (ctrl.state == tap_fsm_pkg::tap_st_ir_update) begin
            // Unlisted codes are kept as is and decode to BYPASS
            instr <= tap_fsm_pkg::tap_instr_e'(ir_sreg);
        end
    end

    // Shifted bits land in the instruction on the next Update-IR
    tdi_known_a: assert property (
        @(posedge tck) disable iff (!trst_n)
        ctrl.ir_shift |-> !$isunknown(tdi)
    ) else $error("tap_ir: tdi unknown in Shift-IR");

endmodule

`default_nettype wire

// ==== source/tap_tdo_out.sv ====
// ------------------------------------------------
// TDO source select and falling edge output regs
// ------------------------------------------------
`default_nettype none

module tap_tdo_out (
    input  logic tck,
    input  logic trst_n,
    tap_ctrl_if.ctrl ctrl,
    input  logic ir_tdo,
    input  logic dr_tdo,
    output logic tdo,
    output logic tdo_en
);

    logic tdo_mux;
    logic tdo_en_mux;

    // DR shift wins, both never overlap anyway
    always_comb begin
        tdo_mux    = 1'b0;
        tdo_en_mux = 1'b0;
        if (ctrl.dr_shift) begin
            tdo_mux    = dr_tdo;
            tdo_en_mux = 1'b1;
        end else if (ctrl.ir_shift) begin
            tdo_mux    = ir_tdo;
            tdo_en_mux = 1'b1;
        end
    end

    // Falling edge so the host samples a stable bit on rise
    always_ff @(negedge tck or negedge trst_n) begin
        if (!trst_n) begin
            tdo    <= 1'b0;
            tdo_en <= 1'b0;
        end else if (!ctrl.sync_rst_n) begin
            tdo    <= 1'b0;
            tdo_en <= 1'b0;
        end else begin
            tdo    <= tdo_mux;
            tdo_en <= tdo_en_mux;
        end
    end

endmodule

`default_nettype wire

// ==== source/tapc_top.sv ====
// ------------------------------------------------
// JTAG TAP controller top, JTAG pins, fuse input
// and the DMI scan chain port
// ------------------------------------------------
`default_nettype none

module tapc_top (
    input  logic trst_n,
    input  logic tck,
    input  logic tms,
    input  logic tdi,
    output logic tdo,
    output logic tdo_en,
    input  logic [tap_dr_pkg::tap_idcode_width-1:0] fuse_idcode,
    output logic dmi_ch_sel,                // DMI chain select
    output tap_dr_pkg::dmi_ch_id_t dmi_ch_id,
    output logic dmi_ch_capture,
    output logic dmi_ch_shift,
    output logic dmi_ch_update,
    output logic dmi_ch_tdi,
    input  logic dmi_ch_tdo
);

    tap_fsm_pkg::tap_instr_e instr;
    logic ir_tdo;
    logic dr_tdo;

    tap_ctrl_if ctrl_if ();

    tap_fsm u_fsm (.tck, .trst_n, .tms, .ctrl(ctrl_if.fsm));

    tap_ir u_ir (.tck, .trst_n, .tdi, .ctrl(ctrl_if.ctrl), .instr, .ir_tdo);

    tap_dr_chains u_dr (
        .tck, .trst_n, .tdi, .ctrl(ctrl_if.ctrl),
        .instr, .fuse_idcode, .dmi_ch_tdo,
        .dmi_ch_sel, .dmi_ch_id, .dr_tdo
    );

    tap_tdo_out u_tdo (.tck, .trst_n, .ctrl(ctrl_if.ctrl), .ir_tdo, .dr_tdo, .tdo, .tdo_en);

    // DMI chain strobes follow the DR strobes directly
    assign dmi_ch_capture = ctrl_if.dr_capture;
    assign dmi_ch_shift   = ctrl_if.dr_shift;
    assign dmi_ch_update  = ctrl_if.dr_update;
    assign dmi_ch_tdi     = tdi;

endmodule

`default_nettype wire

// ==== tb/tapc_checker.sv ====
// ------------------------------------------------
// Reference TAP model, expected TDO function,
// port comparisons and strobe pulse counters
// ------------------------------------------------
`default_nettype none

module tapc_checker (
    input  logic tck,
    input  logic trst_n,
    input  logic tms,
    input  logic tdi,
    input  logic tdo,
    input  logic tdo_en,
    input  logic [31:0] fuse_idcode,
    input  logic dmi_ch_sel,
    input  tap_dr_pkg::dmi_ch_id_t dmi_ch_id,
    input  logic dmi_ch_capture,
    input  logic dmi_ch_shift,
    input  logic dmi_ch_update,
    input  logic dmi_ch_tdi,
    input  logic dmi_ch_tdo
);
    timeunit 1ns;
    timeprecision 1ps;

    tap_fsm_pkg::tap_state_e st;       // State of the current cycle
    tap_fsm_pkg::tap_state_e prev_st;  // State one cycle back
    logic [4:0]  instr;                // Model instruction
    logic [4:0]  instr_now;
    logic [4:0]  ir_sh;                // Model IR shift stage
    logic [31:0] dr_sh;                // Model DR shift stage
    logic        dmi_now;
    logic [1:0]  exp_id;
    int err_count   = 0;
    int cap_count   = 0;
    int shift_count = 0;
    int upd_count   = 0;

    // IEEE 1149.1 state transitions
    function automatic tap_fsm_pkg::tap_state_e next_state(tap_fsm_pkg::tap_state_e s, logic t);
        case (s)
            tap_fsm_pkg::tap_st_reset:
                return t ? tap_fsm_pkg::tap_st_reset : tap_fsm_pkg::tap_st_idle;
            tap_fsm_pkg::tap_st_dr_sel_scan:
                return t ? tap_fsm_pkg::tap_st_ir_sel_scan : tap_fsm_pkg::tap_st_dr_capture;
            tap_fsm_pkg::tap_st_ir_sel_scan:
                return t ? tap_fsm_pkg::tap_st_reset : tap_fsm_pkg::tap_st_ir_capture;
            tap_fsm_pkg::tap_st_dr_capture, tap_fsm_pkg::tap_st_dr_shift:
                return t ? tap_fsm_pkg::tap_st_dr_exit1 : tap_fsm_pkg::tap_st_dr_shift;
            tap_fsm_pkg::tap_st_dr_exit1:
                return t ? tap_fsm_pkg::tap_st_dr_update : tap_fsm_pkg::tap_st_dr_pause;
            tap_fsm_pkg::tap_st_dr_pause:
                return t ? tap_fsm_pkg::tap_st_dr_exit2 : tap_fsm_pkg::tap_st_dr_pause;
            tap_fsm_pkg::tap_st_dr_exit2:
                return t ? tap_fsm_pkg::tap_st_dr_update : tap_fsm_pkg::tap_st_dr_shift;
            tap_fsm_pkg::tap_st_ir_capture, tap_fsm_pkg::tap_st_ir_shift:
                return t ? tap_fsm_pkg::tap_st_ir_exit1 : tap_fsm_pkg::tap_st_ir_shift;
            tap_fsm_pkg::tap_st_ir_exit1:
                return t ? tap_fsm_pkg::tap_st_ir_update : tap_fsm_pkg::tap_st_ir_pause;
            tap_fsm_pkg::tap_st_ir_pause:
                return t ? tap_fsm_pkg::tap_st_ir_exit2 : tap_fsm_pkg::tap_st_ir_pause;
            tap_fsm_pkg::tap_st_ir_exit2:
                return t ? tap_fsm_pkg::tap_st_ir_update : tap_fsm_pkg::tap_st_ir_shift;
            default:  // Idle and both update states
                return t ? tap_fsm_pkg::tap_st_dr_sel_scan : tap_fsm_pkg::tap_st_idle;
        endcase
    endfunction

    // Expected TDO bit at the rising edge that ends a cycle in state s
    function automatic logic expected_tdo(tap_fsm_pkg::tap_state_e s, logic dmi,
                                          logic [4:0] ir, logic [31:0] dr, logic chain_bit);
        if (s == tap_fsm_pkg::tap_st_ir_shift) return ir[0];
        if (s == tap_fsm_pkg::tap_st_dr_shift) return dmi ? chain_bit : dr[0];
        return 1'b0;
    endfunction

    task automatic compare(string name, logic [31:0] exp_v, logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("MISMATCH t=%0t %s expected %0h got %0h", $time, name, exp_v, act_v);
            err_count++;
        end
    endtask

    // ------------------------------------------------
    // TDO and DMI select, stable at the rising edge
    // ------------------------------------------------
    always @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            st      <= tap_fsm_pkg::tap_st_reset;
            prev_st <= tap_fsm_pkg::tap_st_reset;
            instr   <= 5'h01;
        end else begin
            // IDCODE after a full cycle in reset, new code right after Update-IR
            if (prev_st == tap_fsm_pkg::tap_st_reset) instr_now = 5'h01;
            else if (st == tap_fsm_pkg::tap_st_ir_update) instr_now = ir_sh;
            else instr_now = instr;
            dmi_now = (instr_now == 5'h10) || (instr_now == 5'h11);
            exp_id  = (instr_now == 5'h10) ? 2'd1 : (instr_now == 5'h11) ? 2'd2 : 2'd0;
            compare("tdo_en", 32'((st == tap_fsm_pkg::tap_st_ir_shift) ||
                                  (st == tap_fsm_pkg::tap_st_dr_shift)), 32'(tdo_en));
            compare("tdo", 32'(expected_tdo(st, dmi_now, ir_sh, dr_sh, dmi_ch_tdo)), 32'(tdo));
            compare("dmi_ch_sel", 32'(dmi_now), 32'(dmi_ch_sel));
            compare("dmi_ch_id", 32'(exp_id), 32'(dmi_ch_id));
            if (st == tap_fsm_pkg::tap_st_ir_capture) ir_sh <= 5'b00001;
            if (st == tap_fsm_pkg::tap_st_ir_shift)   ir_sh <= {tdi, ir_sh[4:1]};
            if (st == tap_fsm_pkg::tap_st_dr_capture)
                dr_sh <= (instr_now == 5'h01) ? fuse_idcode : 32'h0;  // BYPASS takes 0
            if (st == tap_fsm_pkg::tap_st_dr_shift)
                dr_sh <= (instr_now == 5'h01) ? {tdi, dr_sh[31:1]} : {31'h0, tdi};
            instr   <= instr_now;
            prev_st <= st;
            st      <= next_state(st, tms);
        end
    end

    // Strobes and pass-through, checked mid cycle
    always @(negedge tck) begin
        if (trst_n) begin
            compare("dmi_ch_capture", 32'(st == tap_fsm_pkg::tap_st_dr_capture),
                    32'(dmi_ch_capture));
            compare("dmi_ch_shift", 32'(st == tap_fsm_pkg::tap_st_dr_shift), 32'(dmi_ch_shift));
            compare("dmi_ch_update", 32'(st == tap_fsm_pkg::tap_st_dr_update),
                    32'(dmi_ch_update));
            compare("dmi_ch_tdi", 32'(tdi), 32'(dmi_ch_tdi));
            cap_count   += int'(dmi_ch_capture);
            shift_count += int'(dmi_ch_shift);
            upd_count   += int'(dmi_ch_update);
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_tapc.sv ====
// ------------------------------------------------
// TAP controller testbench with clock, reset, JTAG
// scan tasks, test sequence and DMI chain model
// ------------------------------------------------
`default_nettype none

module tb_tapc;
    timeunit 1ns;
    timeprecision 1ps;

    logic tck = 1'b0;
    logic trst_n = 1'b1;
    logic tms = 1'b1;
    logic tdi = 1'b0;
    logic tdo, tdo_en;
    logic [31:0] fuse_idcode = 32'h0;
    logic dmi_ch_sel, dmi_ch_capture, dmi_ch_shift, dmi_ch_update, dmi_ch_tdi;
    tap_dr_pkg::dmi_ch_id_t dmi_ch_id;
    logic [40:0] dmi_sr = '0;  // DMI chain model
    logic dmi_ch_tdo;
    int tb_errs = 0;
    int err_mark = 0;

    always #20 tck = ~tck;  // 40 ns period

    tapc_top uut (.*);
    tapc_checker chk (.*);

    // ------------------------------------------------
    // DMI chain model
    // ------------------------------------------------
    always @(posedge tck) begin
        logic [63:0] rnd;
        if (dmi_ch_sel && dmi_ch_capture) begin
            rnd = {$urandom(), $urandom()};
            dmi_sr <= rnd[40:0];
        end else if (dmi_ch_sel && dmi_ch_shift) begin
            dmi_sr <= {dmi_ch_tdi, dmi_sr[40:1]};
        end
    end
    assign dmi_ch_tdo = dmi_sr[0];

    // One TCK cycle with inputs changed 5 ns after the edge
    task automatic step(logic tms_v, logic tdi_v);
        tms = tms_v;
        tdi = tdi_v;
        @(posedge tck);
        #5;
    endtask

    // From Run-Test/Idle back to Run-Test/Idle
    task automatic shift_ir(logic [4:0] code);
        step(1, 0);
        step(1, 0);
        step(0, 0);
        step(0, 0);
        for (int i = 0; i < 5; i++) step(i == 4, code[i]);  // LSB first
        step(1, 0);
        step(0, 0);
    endtask

    task automatic scan_dr(int n, bit with_pause);
        step(1, 0);
        step(0, 0);
        step(0, 0);
        for (int i = 0; i < n; i++) step(i == n - 1, 1'($urandom()));
        if (with_pause) begin
            step(0, 0);
            step(0, 0);
            step(1, 0);
        end
        step(1, 0);
        step(0, 0);
    endtask

    task automatic finish_test(string name);
        $display("test %s: %0d errors", name, chk.err_count + tb_errs - err_mark);
        err_mark = chk.err_count + tb_errs;
    endtask

    task automatic count_check(string name, int exp_v, int act_v);
        if (exp_v != act_v) begin
            $display("MISMATCH t=%0t %s pulses expected %0d got %0d", $time, name, exp_v, act_v);
            tb_errs++;
        end
    endtask

    task automatic tms_reset_check;
        int n;
        for (int i = 0; i < 5; i++) step(1, 0);
        n = 0;
        while (dmi_ch_sel !== 1'b0 && n < 20) begin  // Bounded wait for deselect
            step(1, 0);
            n++;
        end
        if (n >= 20) begin
            $display("dmi_ch_sel never dropped after the TMS reset at t=%0t", $time);
            tb_errs++;
        end
        step(0, 0);
    endtask

    // Run limit
    initial begin
        #2_000_000;
        $display("timeout: test sequence did not finish");
        $display("TESTS FAILED");
        $finish;
    end

    // ------------------------------------------------
    // Test sequence
    // ------------------------------------------------
    initial begin
        int c0, s0, u0;
        void'($urandom(32'h51ff_d55d));
        fuse_idcode = $urandom();
        #2 trst_n = 1'b0;
        repeat (16) @(posedge tck);
        #5 trst_n = 1'b1;
        step(0, 0);
        scan_dr(32, 0);  // IDCODE selected by reset
        finish_test("idcode_after_reset");
        shift_ir(5'h1F);
        scan_dr(24, 0);
        shift_ir(5'h07);  // Unknown code acts as BYPASS
        scan_dr(16, 0);
        finish_test("bypass");
        for (int k = 0; k < 2; k++) begin
            shift_ir(k == 0 ? 5'h10 : 5'h11);
            c0 = chk.cap_count;
            s0 = chk.shift_count;
            u0 = chk.upd_count;
            scan_dr(41, 0);
            count_check("dmi_ch_capture", 1, chk.cap_count - c0);
            count_check("dmi_ch_shift", 41, chk.shift_count - s0);
            count_check("dmi_ch_update", 1, chk.upd_count - u0);
        end
        finish_test("dmi_chains");
        scan_dr(20, 1);  // Through Pause-DR
        finish_test("pause_and_tdo_en");
        tms_reset_check();
        scan_dr(32, 0);
        finish_test("tms_reset");
        $display("summary: %0d errors", chk.err_count + tb_errs);
        if (chk.err_count + tb_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
